// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = tb_dec
FLIST     = dec.f
OBJ_DIR   = obj_dir
LOG       = run.log
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dec.f
dec_pkg.sv
dec_predecode.sv
dec_ib.sv
dec_gpr.sv
dec_decode.sv
dec.sv
tb_dec.sv

// File: dec.sv
/* decode stage top */
`timescale 1ns/100ps
`default_nettype none

module dec
   import dec_pkg::*;
#(
   parameter int IB_DEPTH = 4                 // instruction buffer entries
)(
   input  logic                  clk,
   input  logic                  rst,

   input  logic                  fetch_valid,
   input  instr_u                fetch_instr,
   input  logic [PC_W-1:0]       fetch_pc,
   output logic                  fetch_ready,

   input  logic                  wb_valid,    // writeback, no handshake
   input  logic [REG_ADDR_W-1:0] wb_addr,
   input  logic [XLEN-1:0]       wb_data,

   output logic                  dec_valid,
   input  logic                  dec_ready,
   output instr_class_e          dec_class,
   output logic [PC_W-1:0]       dec_pc,
   output logic [REG_ADDR_W-1:0] dec_rd,
   output logic [XLEN-1:0]       dec_rs1_data,
   output logic [XLEN-1:0]       dec_rs2_data,
   output logic [XLEN-1:0]       dec_immed
);

   logic                  pd_valid;           // predecode -> buffer
   logic                  pd_ready;
   instr_u                pd_instr;
   logic [PC_W-1:0]       pd_pc;
   instr_class_e          pd_class;

   logic                  ib_valid;           // buffer -> decoder
   logic                  ib_ready;
   instr_u                ib_instr;
   logic [PC_W-1:0]       ib_pc;
   instr_class_e          ib_class;

   logic [REG_ADDR_W-1:0] rs1_addr;           // decoder <-> register file
   logic [REG_ADDR_W-1:0] rs2_addr;
   logic [XLEN-1:0]       rs1_data;
   logic [XLEN-1:0]       rs2_data;

   dec_predecode pdec (.*);

   dec_ib #(.IB_DEPTH(IB_DEPTH)) instbuff (.*);

   dec_decode decode (.*);

   dec_gpr arf (.*);

endmodule

`default_nettype wire

// File: dec_decode.sv
/* instruction decoder */
`timescale 1ns/100ps
`default_nettype none

module dec_decode
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,

   input  logic                  ib_valid,    // buffer head
   output logic                  ib_ready,
   input  instr_u                ib_instr,
   input  logic [PC_W-1:0]       ib_pc,
   input  instr_class_e          ib_class,

   output logic [REG_ADDR_W-1:0] rs1_addr,    // to register file
   output logic [REG_ADDR_W-1:0] rs2_addr,
   input  logic [XLEN-1:0]       rs1_data,
   input  logic [XLEN-1:0]       rs2_data,

   output logic                  dec_valid,   // output packet
   input  logic                  dec_ready,
   output instr_class_e          dec_class,
   output logic [PC_W-1:0]       dec_pc,
   output logic [REG_ADDR_W-1:0] dec_rd,
   output logic [XLEN-1:0]       dec_rs1_data,
   output logic [XLEN-1:0]       dec_rs2_data,
   output logic [XLEN-1:0]       dec_immed
);

   localparam int IMM_W = 12;

   logic                  pop;
   logic [REG_ADDR_W-1:0] nxt_rd;
   logic [XLEN-1:0]       nxt_rs1_data;
   logic [XLEN-1:0]       nxt_rs2_data;
   logic [XLEN-1:0]       nxt_immed;

   assign ib_ready = ~dec_valid | dec_ready;  // empty or taken this cycle
   assign pop      = ib_valid & ib_ready;

   // rs1 sits at the same bits in both views
   assign rs1_addr = ib_instr.r.rs1;
   assign rs2_addr = ib_instr.r.rs2;          // junk for I-type, data dropped below

   //**************************************************
   // field selection by class
   //**************************************************
   always_comb begin
      nxt_rd       = '0;
      nxt_rs1_data = '0;
      nxt_rs2_data = '0;
      nxt_immed    = '0;
      case (ib_class)
         CLS_OP: begin
            nxt_rd       = ib_instr.r.rd;
            nxt_rs1_data = rs1_data;
            nxt_rs2_data = rs2_data;
         end
         CLS_OP_IMM, CLS_LOAD: begin
            nxt_rd       = ib_instr.i.rd;
            nxt_rs1_data = rs1_data;
            nxt_immed    = {{(XLEN-IMM_W){ib_instr.i.imm12[IMM_W-1]}}, ib_instr.i.imm12};
         end
         default: ;                             // illegal, all zero
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else if (ib_ready) begin
         dec_valid <= ib_valid;                 // load next or drain
      end
   end

   // packet payload, captured at pop
   always_ff @(posedge clk) begin
      if (pop) begin
         dec_class    <= ib_class;
         dec_pc       <= ib_pc;
         dec_rd       <= nxt_rd;
         dec_rs1_data <= nxt_rs1_data;
         dec_rs2_data <= nxt_rs2_data;
         dec_immed    <= nxt_immed;
      end
   end

   a_dec_hold: assert property (@(posedge clk) disable iff (rst)
      dec_valid && !dec_ready |=> dec_valid && $stable(dec_class) && $stable(dec_pc)
         && $stable(dec_rd) && $stable(dec_rs1_data) && $stable(dec_rs2_data)
         && $stable(dec_immed));

endmodule

`default_nettype wire

// File: dec_gpr.sv
/* general purpose registers */
`timescale 1ns/100ps
`default_nettype none

module dec_gpr
   import dec_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,

   input  logic [REG_ADDR_W-1:0] rs1_addr,
   input  logic [REG_ADDR_W-1:0] rs2_addr,
   output logic [XLEN-1:0]       rs1_data,
   output logic [XLEN-1:0]       rs2_data,

   input  logic                  wb_valid,    // always accepted
   input  logic [REG_ADDR_W-1:0] wb_addr,
   input  logic [XLEN-1:0]       wb_data
);

   localparam int NUM_REGS = 2 ** REG_ADDR_W;

   logic [XLEN-1:0] regs [NUM_REGS-1:1];      // x0 has no storage

   // one read port with write-through
   function automatic logic [XLEN-1:0] rd_port(input logic [REG_ADDR_W-1:0] addr);
      logic [XLEN-1:0] data;
      data = '0;                                // x0 reads zero
      if (addr != '0) begin
         if (wb_valid && wb_addr == addr) data = wb_data;
         else data = regs[addr];
      end
      return data;
   endfunction

   always_comb rs1_data = rd_port(rs1_addr);
   always_comb rs2_data = rd_port(rs2_addr);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < NUM_REGS; i++) regs[i] <= '0;
      end else if (wb_valid && wb_addr != '0) begin
         regs[wb_addr] <= wb_data;              // writes to x0 dropped
      end
   end

endmodule

`default_nettype wire

// File: dec_ib.sv
/* instruction buffer */
`timescale 1ns/100ps
`default_nettype none

module dec_ib
   import dec_pkg::*;
#(
   parameter int IB_DEPTH = 4                 // power of two, 2 or more
)(
   input  logic              clk,
   input  logic              rst,

   input  logic              pd_valid,        // push side
   output logic              pd_ready,
   input  instr_u            pd_instr,
   input  logic [PC_W-1:0]   pd_pc,
   input  instr_class_e      pd_class,

   output logic              ib_valid,        // pop side, oldest entry
   input  logic              ib_ready,
   output instr_u            ib_instr,
   output logic [PC_W-1:0]   ib_pc,
   output instr_class_e      ib_class
);

   localparam int PTR_W = $clog2(IB_DEPTH);
   localparam int CNT_W = $clog2(IB_DEPTH + 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(IB_DEPTH);

   instr_u          mem_instr [IB_DEPTH];     // entry storage
   logic [PC_W-1:0] mem_pc    [IB_DEPTH];
   instr_class_e    mem_class [IB_DEPTH];

   logic [PTR_W-1:0] wr_ptr;                  // next free slot
   logic [PTR_W-1:0] rd_ptr;                  // oldest entry
   logic [CNT_W-1:0] count;                   // occupancy
   logic             push;
   logic             pop;

   assign pd_ready = (count != FULL_CNT);
   assign ib_valid = (count != '0);
   assign push     = pd_valid & pd_ready;
   assign pop      = ib_valid & ib_ready;

   assign ib_instr = mem_instr[rd_ptr];       // head always shown
   assign ib_pc    = mem_pc[rd_ptr];
   assign ib_class = mem_class[rd_ptr];

   //**************************************************
   // pointers and occupancy
   //**************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // idle or push+pop
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem_instr[wr_ptr] <= pd_instr;
         mem_pc[wr_ptr]    <= pd_pc;
         mem_class[wr_ptr] <= pd_class;
      end
   end

   a_ib_max: assert property (@(posedge clk) disable iff (rst) count <= FULL_CNT);

   // an empty buffer can only gain, an underflow would wrap the count
   a_ib_no_underflow: assert property (@(posedge clk) disable iff (rst)
      count == '0 |=> count <= CNT_W'(1));

endmodule

`default_nettype wire

// File: dec_pkg.sv
/* decode stage shared definitions */
`default_nettype none

package dec_pkg;

   //**************************************************
   // widths
   //**************************************************
   localparam int XLEN       = 32;                 // data and instruction word
   localparam int REG_ADDR_W = 5;                  // register index
   localparam int PC_W       = 31;                 // pc[31:1], halfword aligned

   //**************************************************
   // major opcodes accepted
   //**************************************************
   localparam logic [6:0] OPC_OP     = 7'b0110011; // reg-reg alu
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // reg-imm alu
   localparam logic [6:0] OPC_LOAD   = 7'b0000011; // loads

   typedef enum logic [1:0] {
      CLS_OP      = 2'b00,                         // rs1 op rs2
      CLS_OP_IMM  = 2'b01,                         // rs1 op imm12
      CLS_LOAD    = 2'b10,                         // rs1 + imm12
      CLS_ILLEGAL = 2'b11                          // anything else
   } instr_class_e;

   // R-type view of the word
   typedef struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
   } r_fields_t;

   // I-type view, imm12 overlays funct7 and rs2
   typedef struct packed {
      logic [11:0]           imm12;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
   } i_fields_t;

   typedef union packed {
      r_fields_t r;                                // read this for CLS_OP
      i_fields_t i;                                // op_imm and load
   } instr_u;

endpackage

`default_nettype wire

// File: dec_predecode.sv
/* fetch intake and predecode */
`timescale 1ns/100ps
`default_nettype none

module dec_predecode
   import dec_pkg::*;
(
   input  logic              clk,
   input  logic              rst,

   input  logic              fetch_valid,     // word offered by fetch
   input  instr_u            fetch_instr,
   input  logic [PC_W-1:0]   fetch_pc,
   output logic              fetch_ready,

   output logic              pd_valid,        // held word toward buffer
   input  logic              pd_ready,        // buffer not full
   output instr_u            pd_instr,
   output logic [PC_W-1:0]   pd_pc,
   output instr_class_e      pd_class
);

   logic         fetch_xfer;                  // fetch handshake this cycle
   instr_class_e fetch_class;                 // class of the incoming word

   assign fetch_ready = ~pd_valid | pd_ready; // empty or draining now
   assign fetch_xfer  = fetch_valid & fetch_ready;

   //**************************************************
   // classify on entry
   //**************************************************
   always_comb begin
      if (fetch_instr.r.opcode[1:0] != 2'b11) begin
         fetch_class = CLS_ILLEGAL;            // compressed space, not supported
      end else begin
         case (fetch_instr.r.opcode)
            OPC_OP:     fetch_class = CLS_OP;
            OPC_OP_IMM: fetch_class = CLS_OP_IMM;
            OPC_LOAD:   fetch_class = CLS_LOAD;
            default:    fetch_class = CLS_ILLEGAL;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pd_valid <= 1'b0;
      end else if (fetch_ready) begin
         pd_valid <= fetch_valid;               // refill or go empty
      end
   end

   // payload, loaded only on a fetch transfer
   always_ff @(posedge clk) begin
      if (fetch_xfer) begin
         pd_instr <= fetch_instr;
         pd_pc    <= fetch_pc;
         pd_class <= fetch_class;
      end
   end

   a_pd_hold: assert property (@(posedge clk) disable iff (rst)
      pd_valid && !pd_ready |=> pd_valid && $stable(pd_instr) && $stable(pd_pc)
         && $stable(pd_class));

endmodule

`default_nettype wire

// File: tb_dec.sv
/* decode stage testbench */
`timescale 1ns/100ps
`default_nettype none

module tb_dec
   import dec_pkg::*;
();

   typedef struct packed {
      logic [1:0]            cls;
      logic [PC_W-1:0]       pc;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       rs1;
      logic [XLEN-1:0]       rs2;
      logic [XLEN-1:0]       imm;
      logic [31:0]           cyc;                // edge count at fetch transfer
   } exp_pkt_t;

   logic clk = 1'b0;
   logic rst, fetch_valid, fetch_ready, wb_valid, dec_valid, dec_ready;
   instr_u fetch_instr;
   logic [PC_W-1:0] fetch_pc, dec_pc, next_pc;
   logic [REG_ADDR_W-1:0] wb_addr, dec_rd;
   logic [XLEN-1:0] wb_data, dec_rs1_data, dec_rs2_data, dec_immed;
   instr_class_e dec_class;

   logic [15:0] lfsr = 16'd37368;
   logic [XLEN-1:0] shadow [32];                 // expected register contents
   exp_pkt_t exp_q [$];
   exp_pkt_t exp_head;                           // oldest expected packet
   logic [31:0] cyc = 32'd0;
   int q_cnt = 0, errors = 0, tests = 0, errors_start = 0;
   bit saw_full = 1'b0, timed_out = 1'b0;
   string test_name = "reset";

   dec #(.IB_DEPTH(4)) UUT (.*);

   always #2 clk = ~clk;                         // 4 ns period

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [31:0] gen_word();
      logic [2:0] pick;
      logic [24:0] upper;
      logic [6:0] opc;
      logic [4:0] hi5;
      logic lo1;
      pick = 3'(take_bits(3));
      upper = 25'(take_bits(25));                // random fields including imm sign
      case (pick)
         3'd0, 3'd1: opc = OPC_OP;
         3'd2, 3'd3: opc = OPC_OP_IMM;
         3'd4, 3'd5: opc = OPC_LOAD;
         3'd6: opc = 7'b0110111;                 // lui is unknown here
         default: begin
            hi5 = 5'(take_bits(5));
            lo1 = 1'(take_bits(1));
            opc = {hi5, 1'b0, lo1};              // low bits never 2'b11
         end
      endcase
      return {upper, opc};
   endfunction

   // expected packet straight from the class rules
   function automatic exp_pkt_t build_exp(input logic [31:0] word, input logic [PC_W-1:0] pc,
                                          input logic [31:0] now);
      exp_pkt_t p;
      p = '0;
      p.pc = pc;
      p.cyc = now;
      if (word[1:0] != 2'b11) p.cls = CLS_ILLEGAL;
      else if (word[6:0] == OPC_OP) p.cls = CLS_OP;
      else if (word[6:0] == OPC_OP_IMM) p.cls = CLS_OP_IMM;
      else if (word[6:0] == OPC_LOAD) p.cls = CLS_LOAD;
      else p.cls = CLS_ILLEGAL;
      if (p.cls != CLS_ILLEGAL) begin
         p.rd = word[11:7];
         p.rs1 = shadow[word[19:15]];
      end
      if (p.cls == CLS_OP) p.rs2 = shadow[word[24:20]];
      if (p.cls == CLS_OP_IMM || p.cls == CLS_LOAD) p.imm = {{20{word[31]}}, word[31:20]};
      return p;
   endfunction

   //**************************************************
   // scoreboard on pre-edge values at each rising edge
   //**************************************************
   always @(posedge clk) begin
      if (rst) begin
         exp_q.delete();
      end else begin
         if (dec_valid && dec_ready && exp_q.size() > 0) void'(exp_q.pop_front());
         if (fetch_valid && fetch_ready) exp_q.push_back(build_exp(fetch_instr, fetch_pc, cyc));
         if (!fetch_ready) saw_full = 1'b1;     // back-pressure reached fetch
      end
      cyc = cyc + 32'd1;
      q_cnt = exp_q.size();
      exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
   end

   //**************************************************
   // checks
   //**************************************************
   a_reset: assert property (@(posedge clk) rst |=> !dec_valid && !UUT.pd_valid && !UUT.ib_valid)
      else begin
         $display("reset left a valid high in %s", test_name);
         errors++;
      end
   a_extra: assert property (@(posedge clk) disable iff (rst) dec_valid |-> q_cnt > 0)
      else begin
         $display("packet in %s with no fetched word behind it", test_name);
         errors++;
      end
   a_class: assert property (@(posedge clk) disable iff (rst) dec_valid && dec_ready |->
      dec_class == exp_head.cls) else begin
      $display("ERROR %s class expected %0d actual %0d", test_name, $sampled(exp_head.cls),
         $sampled(dec_class));
      errors++;
   end
   a_pc: assert property (@(posedge clk) disable iff (rst) dec_valid && dec_ready |->
      dec_pc == exp_head.pc) else begin
      $display("ERROR %s pc expected %h actual %h", test_name, $sampled(exp_head.pc),
         $sampled(dec_pc));
      errors++;
   end
   a_rd: assert property (@(posedge clk) disable iff (rst) dec_valid && dec_ready |->
      dec_rd == exp_head.rd) else begin
      $display("ERROR %s rd expected %0d actual %0d", test_name, $sampled(exp_head.rd),
         $sampled(dec_rd));
      errors++;
   end
   a_rs1: assert property (@(posedge clk) disable iff (rst) dec_valid && dec_ready |->
      dec_rs1_data == exp_head.rs1) else begin
      $display("ERROR %s rs1 expected %h actual %h", test_name, $sampled(exp_head.rs1),
         $sampled(dec_rs1_data));
      errors++;
   end
   a_rs2: assert property (@(posedge clk) disable iff (rst) dec_valid && dec_ready |->
      dec_rs2_data == exp_head.rs2) else begin
      $display("ERROR %s rs2 expected %h actual %h", test_name, $sampled(exp_head.rs2),
         $sampled(dec_rs2_data));
      errors++;
   end
   a_imm: assert property (@(posedge clk) disable iff (rst) dec_valid && dec_ready |->
      dec_immed == exp_head.imm) else begin
      $display("ERROR %s immed expected %h actual %h", test_name, $sampled(exp_head.imm),
         $sampled(dec_immed));
      errors++;
   end
   a_latency: assert property (@(posedge clk) disable iff (rst) dec_valid && dec_ready |->
      (cyc - exp_head.cyc) >= 32'd3)
      else begin
         $display("packet in %s came out faster than three cycles", test_name);
         errors++;
      end
   a_stall: assert property (@(posedge clk) disable iff (rst) dec_valid && !dec_ready |=>
      dec_valid && $stable(dec_class) && $stable(dec_pc) && $stable(dec_rd)
      && $stable(dec_rs1_data) && $stable(dec_rs2_data) && $stable(dec_immed))
      else begin
         $display("output packet moved while stalled in %s", test_name);
         errors++;
      end

   task automatic end_test();
      $display("test %s done, %0d errors", test_name, errors - errors_start);
      tests++;
      errors_start = errors;
   endtask

   // offer n words with random gaps and mostly low dec_ready when stalling
   task automatic run_words(input int n, input bit stall);
      int offered, sent, guard;
      logic accepted;
      offered = 0;
      sent = 0;
      guard = 0;
      while (sent < n && !timed_out) begin
         @(posedge clk);
         accepted = fetch_valid && fetch_ready;
         #1;
         if (accepted) begin
            sent++;
            fetch_valid = 1'b0;
         end
         if (!fetch_valid && offered < n && take_bits(2) != 32'd0) begin
            fetch_instr = gen_word();
            fetch_pc = next_pc;
            next_pc = next_pc + PC_W'(2);        // next 4-byte word
            fetch_valid = 1'b1;
            offered++;
         end
         dec_ready = stall ? (take_bits(3) == 32'd0) : 1'b1;
         guard++;
         if (guard > 50 * n + 100) begin
            $display("timeout in %s, fetch stopped accepting words", test_name);
            timed_out = 1'b1;
         end
      end
      fetch_valid = 1'b0;
   endtask

   task automatic drain();
      int guard;
      guard = 0;
      dec_ready = 1'b1;
      while ((q_cnt != 0 || dec_valid) && !timed_out) begin
         @(posedge clk);
         #1;
         guard++;
         if (guard > 200) begin
            $display("timeout in %s, packets still missing at the output", test_name);
            timed_out = 1'b1;
         end
      end
   endtask

   initial begin
      rst = 1'b1;
      fetch_valid = 1'b0;
      fetch_instr = '0;
      fetch_pc = '0;
      next_pc = PC_W'(32'h40);
      wb_valid = 1'b0;
      wb_addr = '0;
      wb_data = '0;
      dec_ready = 1'b1;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
      assert (!dec_valid) else begin
         $display("dec_valid high after reset");
         errors++;
      end
      end_test();

      test_name = "preload";                     // x0 written too and must stay zero
      for (int i = 0; i < 32; i++) begin
         @(posedge clk);
         #1;
         wb_valid = 1'b1;
         wb_addr = 5'(i);
         wb_data = take_bits(32);
         shadow[i] = (i == 0) ? '0 : wb_data;
      end
      @(posedge clk);
      #1 wb_valid = 1'b0;
      end_test();

      test_name = "random";
      run_words(80, 1'b0);
      drain();
      end_test();

      test_name = "backpressure";
      saw_full = 1'b0;
      run_words(60, 1'b1);
      drain();
      assert (saw_full) else begin
         $display("fetch_ready never dropped under stalls");
         errors++;
      end
      end_test();

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0 && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire
